//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_vio_switch
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- design/dest_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module dest_arbiter (
  input  logic                       aclk,
  input  logic                       reset,
  input  switch_cfg_pkg::port_mask_t req,
  input  stream_pkg::axis_beat_t     beats [switch_cfg_pkg::N_PORTS],
  input  logic                       stage_ready,
  output switch_cfg_pkg::port_mask_t grant,
  output logic                       grant_valid,
  output stream_pkg::axis_beat_t     grant_beat
);

  // Holder of the current packet, or the last winner when unlocked
  switch_cfg_pkg::port_idx_t last_idx;
  logic                      locked;

  switch_cfg_pkg::port_idx_t rr_idx;
  logic                      rr_hit;
  switch_cfg_pkg::port_idx_t cand_idx;
  switch_cfg_pkg::port_idx_t sel_idx;

  // Search starts one past the last winner and wraps
  always_comb begin
    rr_idx = last_idx;
    rr_hit = 1'b0;
    cand_idx = last_idx;
    for (int k = 1; k <= switch_cfg_pkg::N_PORTS; k++) begin
      cand_idx = switch_cfg_pkg::port_idx_t'(
        (int'(last_idx) + k) % switch_cfg_pkg::N_PORTS);
      if (!rr_hit && req[cand_idx]) begin
        rr_idx = cand_idx;
        rr_hit = 1'b1;
      end
    end
  end

  // Inside a packet the holder keeps the grant even while it idles
  always_comb begin
    if (locked) begin
      sel_idx = last_idx;
      grant_valid = req[last_idx];
    end else begin
      sel_idx = rr_idx;
      grant_valid = rr_hit;
    end
  end

  assign grant = grant_valid ? (switch_cfg_pkg::port_mask_t'(1) << sel_idx) : '0;

  // Data mux toward the output stage
  assign grant_beat = beats[sel_idx];

  // Lock on the first beat, release when the last beat moves
  always_ff @(posedge aclk) begin
    if (reset) begin
      locked <= 1'b0;
      last_idx <= switch_cfg_pkg::port_idx_t'(switch_cfg_pkg::N_PORTS - 1);
    end else if (grant_valid && stage_ready) begin
      last_idx <= sel_idx;
      locked <= !grant_beat.last;
    end
  end

endmodule

`default_nettype wire

//--- design/output_stage.sv
`default_nettype none
`timescale 1ns/1ps

module output_stage (
  input  logic                   aclk,
  input  logic                   reset,
  input  logic                   in_valid,
  input  stream_pkg::axis_beat_t in_beat,
  output logic                   stage_ready,
  output logic                   out_valid,
  output stream_pkg::axis_beat_t out_beat,
  input  logic                   out_ready
);

  // Room when empty or when the held beat leaves this cycle
  assign stage_ready = !out_valid || out_ready;

  always_ff @(posedge aclk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (stage_ready) begin
      out_valid <= in_valid;
    end
  end

  // Held beat stays put under back-pressure
  always_ff @(posedge aclk) begin
    if (stage_ready && in_valid) begin
      out_beat <= in_beat;
    end
  end

endmodule

`default_nettype wire

//--- design/route_decode.sv
`default_nettype none
`timescale 1ns/1ps

module route_decode (
  input  logic                       aclk,
  input  logic                       reset,
  input  stream_pkg::axis_beat_t     beat,
  input  logic                       valid,
  output switch_cfg_pkg::port_mask_t dest_req,
  output logic                       bad_dest,
  output logic                       decode_err
);

  switch_cfg_pkg::port_idx_t dest_idx;
  logic                      upper_clear;
  logic                      dest_ok;

  // Low bits pick the port
  assign dest_idx = beat.tdest[switch_cfg_pkg::PORT_BITS-1:0];

  // Any set bit above the index field makes the route invalid
  assign upper_clear =
    (beat.tdest[stream_pkg::DEST_BITS-1:switch_cfg_pkg::PORT_BITS] == '0);

  assign dest_ok = upper_clear && (int'(dest_idx) < switch_cfg_pkg::N_PORTS);

  // One-hot request toward the arbiter of the selected destination
  assign dest_req = (valid && dest_ok) ?
    (switch_cfg_pkg::port_mask_t'(1) << dest_idx) : '0;

  // Bad beats are taken at once and dropped by the top level
  assign bad_dest = valid && !dest_ok;

  // Flag follows the edge that swallowed the beat
  always_ff @(posedge aclk) begin
    if (reset) begin
      decode_err <= 1'b0;
    end else begin
      decode_err <= bad_dest;
    end
  end

endmodule

`default_nettype wire

//--- design/stream_pkg.sv
`default_nettype none

package stream_pkg;

  localparam int DATA_BITS = 64;
  localparam int PID_BITS = 6;

  // Routing field, only the low bits select a port
  localparam int DEST_BITS = 14;

  // One full beat, every byte of data is valid
  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic [PID_BITS-1:0]  tid;
    logic [DEST_BITS-1:0] tdest;
    logic                 last;
  } axis_beat_t;

endpackage

`default_nettype wire

//--- design/switch_cfg_pkg.sv
`default_nettype none

package switch_cfg_pkg;

  // Region ports come first, the service ports follow
  localparam int N_VFIU = 2;
  localparam int N_PORTS = N_VFIU + 3;

  // Service port indices
  localparam int PORT_HOST = N_VFIU;
  localparam int PORT_RDMA = N_VFIU + 1;
  localparam int PORT_TCP = N_VFIU + 2;

  // Width of a port index, must cover N_PORTS-1
  localparam int PORT_BITS = 3;

  typedef logic [PORT_BITS-1:0] port_idx_t;

  // One bit per port, bit i belongs to port i
  typedef logic [N_PORTS-1:0] port_mask_t;

endpackage

`default_nettype wire

//--- design/vio_switch.sv
`default_nettype none
`timescale 1ns/1ps

// Ports 0..N_VFIU-1 are regions, then host, RDMA and TCP
module vio_switch (
  input  logic                       aclk,
  input  logic                       reset,

  // Sources
  input  stream_pkg::axis_beat_t     in_beat [switch_cfg_pkg::N_PORTS],
  input  switch_cfg_pkg::port_mask_t in_valid,
  output switch_cfg_pkg::port_mask_t in_ready,

  // Destinations
  output stream_pkg::axis_beat_t     out_beat [switch_cfg_pkg::N_PORTS],
  output switch_cfg_pkg::port_mask_t out_valid,
  input  switch_cfg_pkg::port_mask_t out_ready,

  output switch_cfg_pkg::port_mask_t decode_err
);

  // Indexed by source, one bit per destination
  switch_cfg_pkg::port_mask_t dest_req [switch_cfg_pkg::N_PORTS];
  switch_cfg_pkg::port_mask_t bad_dest;

  // Indexed by destination, one bit per source
  switch_cfg_pkg::port_mask_t arb_req [switch_cfg_pkg::N_PORTS];
  switch_cfg_pkg::port_mask_t grant [switch_cfg_pkg::N_PORTS];

  switch_cfg_pkg::port_mask_t grant_valid;
  switch_cfg_pkg::port_mask_t stage_ready;
  stream_pkg::axis_beat_t     grant_beat [switch_cfg_pkg::N_PORTS];

  for (genvar s = 0; s < switch_cfg_pkg::N_PORTS; s++) begin : g_src
    route_decode u_decode (
      .aclk       (aclk),
      .reset      (reset),
      .beat       (in_beat[s]),
      .valid      (in_valid[s]),
      .dest_req   (dest_req[s]),
      .bad_dest   (bad_dest[s]),
      .decode_err (decode_err[s])
    );
  end

  // Request matrix turned around so each arbiter sees its column
  for (genvar d = 0; d < switch_cfg_pkg::N_PORTS; d++) begin : g_xpose
    for (genvar s = 0; s < switch_cfg_pkg::N_PORTS; s++) begin : g_bit
      assign arb_req[d][s] = dest_req[s][d];
    end
  end

  for (genvar d = 0; d < switch_cfg_pkg::N_PORTS; d++) begin : g_dst
    dest_arbiter u_arb (
      .aclk        (aclk),
      .reset       (reset),
      .req         (arb_req[d]),
      .beats       (in_beat),
      .stage_ready (stage_ready[d]),
      .grant       (grant[d]),
      .grant_valid (grant_valid[d]),
      .grant_beat  (grant_beat[d])
    );

    output_stage u_stage (
      .aclk        (aclk),
      .reset       (reset),
      .in_valid    (grant_valid[d]),
      .in_beat     (grant_beat[d]),
      .stage_ready (stage_ready[d]),
      .out_valid   (out_valid[d]),
      .out_beat    (out_beat[d]),
      .out_ready   (out_ready[d])
    );
  end

  // A source is ready when dropped, or when granted by a destination with room
  always_comb begin
    in_ready = bad_dest;
    for (int d = 0; d < switch_cfg_pkg::N_PORTS; d++) begin
      in_ready = in_ready | (grant[d] & {switch_cfg_pkg::N_PORTS{stage_ready[d]}});
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_vio_switch.sv
`default_nettype none
`timescale 1ns/1ps

module tb_vio_switch;

  localparam int TIMEOUT_CYCLES = 50;

  // One stimulus row, the expected result is a destination or a decode error
  typedef struct packed {
    switch_cfg_pkg::port_idx_t        src;
    logic [stream_pkg::DEST_BITS-1:0] tdest;
    logic [stream_pkg::PID_BITS-1:0]  tid;
    logic [3:0]                       len;
    logic                             stall;
    logic                             exp_err;
    switch_cfg_pkg::port_idx_t        exp_dest;
  } vec_t;

  logic                       aclk;
  logic                       reset;
  stream_pkg::axis_beat_t     in_beat [switch_cfg_pkg::N_PORTS];
  switch_cfg_pkg::port_mask_t in_valid;
  switch_cfg_pkg::port_mask_t in_ready;
  stream_pkg::axis_beat_t     out_beat [switch_cfg_pkg::N_PORTS];
  switch_cfg_pkg::port_mask_t out_valid;
  switch_cfg_pkg::port_mask_t out_ready;
  switch_cfg_pkg::port_mask_t decode_err;

  integer                 seed;
  vec_t                   vec_q [$];
  stream_pkg::axis_beat_t tx_q [switch_cfg_pkg::N_PORTS][$];
  stream_pkg::axis_beat_t rx_q [$];

  vio_switch UUT (
    .aclk       (aclk),
    .reset      (reset),
    .in_beat    (in_beat),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .out_beat   (out_beat),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .decode_err (decode_err)
  );

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  function automatic switch_cfg_pkg::port_mask_t one_hot(input int idx);
    return switch_cfg_pkg::port_mask_t'(1) << idx;
  endfunction

  // Reference round-robin, first requester after the last winner
  function automatic int rr_pick(input int last, input switch_cfg_pkg::port_mask_t req);
    int idx;
    for (int k = 1; k <= switch_cfg_pkg::N_PORTS; k++) begin
      idx = (last + k) % switch_cfg_pkg::N_PORTS;
      if (req[idx]) begin
        return idx;
      end
    end
    return -1;
  endfunction

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_beat(input string name, input int dest,
                            input stream_pkg::axis_beat_t exp);
    if (out_beat[dest] !== exp) begin
      $display("error %s expected %h actual %h", name, exp, out_beat[dest]);
      abort_run();
    end
  endtask

  task automatic check_err(input string name, input switch_cfg_pkg::port_mask_t exp);
    if (decode_err !== exp) begin
      $display("error %s decode_err expected %b actual %b", name, exp, decode_err);
      abort_run();
    end
  endtask

  task automatic check_flags(input string name, input switch_cfg_pkg::port_mask_t exp,
                             input switch_cfg_pkg::port_mask_t act);
    if (act !== exp) begin
      $display("error %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  function automatic void add_vec(input int src, input int tdest, input int tid,
                                  input int len, input bit stall, input bit exp_err,
                                  input int exp_dest);
    vec_t v;
    v.src = switch_cfg_pkg::port_idx_t'(src);
    v.tdest = tdest[stream_pkg::DEST_BITS-1:0];
    v.tid = tid[stream_pkg::PID_BITS-1:0];
    v.len = len[3:0];
    v.stall = stall;
    v.exp_err = exp_err;
    v.exp_dest = switch_cfg_pkg::port_idx_t'(exp_dest);
    vec_q.push_back(v);
  endfunction

  function automatic void build_table();
    // Every source to every port, one beat each
    for (int s = 0; s < switch_cfg_pkg::N_PORTS; s++) begin
      for (int d = 0; d < switch_cfg_pkg::N_PORTS; d++) begin
        add_vec(s, d, s * 8 + d, 1, 1'b0, 1'b0, d);
      end
    end
    // Out of range or high bits set
    add_vec(0, 5, 1, 1, 1'b0, 1'b1, 0);
    add_vec(2, 7, 2, 1, 1'b0, 1'b1, 0);
    add_vec(4, 'h0101, 3, 1, 1'b0, 1'b1, 0);
    add_vec(3, 'h2000, 4, 1, 1'b0, 1'b1, 0);
    // Packets and back-pressure
    add_vec(1, switch_cfg_pkg::PORT_RDMA, 10, 4, 1'b0, 1'b0, switch_cfg_pkg::PORT_RDMA);
    add_vec(4, 0, 11, 3, 1'b0, 1'b0, 0);
    add_vec(0, switch_cfg_pkg::PORT_HOST, 12, 2, 1'b1, 1'b0, switch_cfg_pkg::PORT_HOST);
    add_vec(3, switch_cfg_pkg::PORT_TCP, 13, 3, 1'b1, 1'b0, switch_cfg_pkg::PORT_TCP);
  endfunction

  task automatic load_packet(input int src, input logic [stream_pkg::DEST_BITS-1:0] tdest,
                             input logic [stream_pkg::PID_BITS-1:0] tid, input int len,
                             input bit expect_out);
    stream_pkg::axis_beat_t b;
    for (int i = 0; i < len; i++) begin
      b.data = {$random(seed), $random(seed)};
      b.tid = tid;
      b.tdest = tdest;
      b.last = (i == len - 1);
      tx_q[src].push_back(b);
      if (expect_out) begin
        rx_q.push_back(b);
      end
    end
  endtask

  // Returns just after the edge that moved the beat
  task automatic wait_ready(input int src);
    int n;
    n = 0;
    @(negedge aclk);
    while (!in_ready[src]) begin
      n++;
      if (n > TIMEOUT_CYCLES) begin
        $display("timeout waiting for in_ready of source %0d", src);
        abort_run();
      end
      @(negedge aclk);
    end
    @(posedge aclk);
  endtask

  task automatic send_packet(input int src);
    stream_pkg::axis_beat_t b;
    while (tx_q[src].size() > 0) begin
      b = tx_q[src].pop_front();
      in_beat[src] <= b;
      in_valid[src] <= 1'b1;
      wait_ready(src);
    end
    in_valid[src] <= 1'b0;
  endtask

  task automatic collect(input int dest, input int count, input string name);
    stream_pkg::axis_beat_t exp;
    int n;
    for (int i = 0; i < count; i++) begin
      n = 0;
      @(negedge aclk);
      while (!(out_valid[dest] && out_ready[dest])) begin
        n++;
        if (n > TIMEOUT_CYCLES) begin
          $display("timeout waiting for out_valid of destination %0d in %s", dest, name);
          abort_run();
        end
        @(negedge aclk);
      end
      exp = rx_q.pop_front();
      check_flags({name, " out_valid"}, one_hot(dest), out_valid);
      check_beat(name, dest, exp);
    end
  endtask

  // Second beat is queued behind a full stage
  task automatic hold_stall(input int dest, input string name);
    repeat (4) @(posedge aclk);
    @(negedge aclk);
    check_flags({name, " in_ready"}, '0, in_ready);
    check_flags({name, " held"}, one_hot(dest), out_valid);
    @(posedge aclk);
    out_ready[dest] <= 1'b1;
  endtask

  task automatic run_entry(input vec_t v, input string name);
    int src;
    int dest;
    src = int'(v.src);
    dest = int'(v.exp_dest);
    load_packet(src, v.tdest, v.tid, int'(v.len), !v.exp_err);
    @(posedge aclk);
    if (v.exp_err) begin
      send_packet(src);
      @(negedge aclk);
      check_err(name, one_hot(src));
      check_flags({name, " dropped"}, '0, out_valid);
      @(negedge aclk);
      check_err(name, '0);
      check_flags({name, " dropped"}, '0, out_valid);
    end else begin
      if (v.stall) begin
        out_ready[dest] <= 1'b0;
      end
      fork
        send_packet(src);
        collect(dest, int'(v.len), name);
        if (v.stall) hold_stall(dest, name);
      join
      @(negedge aclk);
      check_flags({name, " idle"}, '0, out_valid);
    end
    repeat (2) @(posedge aclk);
  endtask

  // Two packets to the host port at once, order from the round-robin rule
  task automatic run_contention();
    int first;
    int second;
    first = rr_pick(switch_cfg_pkg::N_PORTS - 1, one_hot(1) | one_hot(3));
    second = (first == 1) ? 3 : 1;
    load_packet(first, switch_cfg_pkg::PORT_HOST, 20, 3, 1'b1);
    load_packet(second, switch_cfg_pkg::PORT_HOST, 21, 3, 1'b1);
    @(posedge aclk);
    fork
      send_packet(1);
      send_packet(3);
      collect(switch_cfg_pkg::PORT_HOST, 6, "contention");
    join
    repeat (2) @(posedge aclk);
  endtask

  initial begin
    seed = 84508;
    reset = 1'b1;
    in_valid = '0;
    out_ready = '1;
    for (int p = 0; p < switch_cfg_pkg::N_PORTS; p++) begin
      in_beat[p] = '0;
    end
    build_table();
    repeat (4) @(posedge aclk);
    reset <= 1'b0;
    repeat (2) @(posedge aclk);
    run_contention();
    for (int i = 0; i < vec_q.size(); i++) begin
      run_entry(vec_q[i], $sformatf("vec %0d src %0d tdest %0h", i, vec_q[i].src,
                                    vec_q[i].tdest));
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/vio_switch_assert.sv
`default_nettype none
`timescale 1ns/1ps

module vio_switch_assert (
  input logic                       aclk,
  input logic                       reset,
  input switch_cfg_pkg::port_mask_t out_valid,
  input switch_cfg_pkg::port_mask_t out_ready,
  input stream_pkg::axis_beat_t     out_beat [switch_cfg_pkg::N_PORTS],
  input switch_cfg_pkg::port_mask_t decode_err,
  input switch_cfg_pkg::port_mask_t grant [switch_cfg_pkg::N_PORTS]
);

  // Decoder flags come out of reset cleared
  a_err_after_reset: assert property (@(posedge aclk) $past(reset) |-> (decode_err == '0))
    else $error("decode_err high in the cycle after reset");

  for (genvar p = 0; p < switch_cfg_pkg::N_PORTS; p++) begin : g_port
    // A stalled beat must not move or vanish
    a_hold: assert property (@(posedge aclk) disable iff (reset)
      (out_valid[p] && !out_ready[p]) |=> (out_valid[p] && $stable(out_beat[p])))
      else $error("output %0d changed while out_ready was low", p);

    a_grant: assert property (@(posedge aclk) disable iff (reset) $onehot0(grant[p]))
      else $error("arbiter %0d granted more than one source", p);
  end

endmodule

bind vio_switch vio_switch_assert u_assert (
  .aclk       (aclk),
  .reset      (reset),
  .out_valid  (out_valid),
  .out_ready  (out_ready),
  .out_beat   (out_beat),
  .decode_err (decode_err),
  .grant      (grant)
);

`default_nettype wire

//--- src.f
design/switch_cfg_pkg.sv
design/stream_pkg.sv
design/route_decode.sv
design/dest_arbiter.sv
design/output_stage.sv
design/vio_switch.sv
sim/vio_switch_assert.sv
sim/tb_vio_switch.sv
